// ==== files.f ====
+incdir+logic
logic/biu_pkg.sv
logic/biu_data_pipe.sv
logic/biu_ahb_fsm.sv
logic/biu_burst_cnt.sv
logic/ahb_sram_slave.sv
logic/biu_ahb_top.sv
tests/tb_biu_ahb.sv

// ==== logic/ahb_sram_slave.sv ====
////////////////////////////////////////////////////////////////////////////
// decodes HADDR[13:0] only, addr bit 4 adds one wait state
// ERROR for the top 1 KiB and for user-mode writes, memory left untouched
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "biu_consts.svh"

module ahb_sram_slave
  import biu_pkg::*;
(
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   hsel_i,
  input  htrans_t                htrans_i,
  input  logic [`BIU_ADDR_W-1:0] haddr_i,
  input  logic                   hwrite_i,
  input  logic [2:0]             hsize_i,
  input  logic [`HPROT_W-1:0]    hprot_i,
  input  logic [`BIU_DATA_W-1:0] hwdata_i,
  output logic [`BIU_DATA_W-1:0] hrdata_o,
  output logic                   hready_o,
  output hresp_t                 hresp_o
);

  localparam int AW = $clog2(`SRAM_WORDS);   // word index bits

  logic [`BIU_DATA_W-1:0] mem [`SRAM_WORDS];

  logic          ap_valid, ap_err;
  logic [3:0]    ap_be;
  logic          dp_act_q, dp_write_q, dp_err_q, dp_wait_q;
  logic          stall_q;                    // low cycle already served
  logic [AW-1:0] dp_idx_q;
  logic [3:0]    dp_be_q;

  ////////////////////////////////////////////////////////////////////////////
  // address phase decode
  ////////////////////////////////////////////////////////////////////////////
  assign ap_valid = hsel_i & (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);
  assign ap_err   = (haddr_i[AW+1:0] >= `SRAM_ERR_BASE) |
                    (hwrite_i & ~|(hprot_i & `HPROT_PRIV));

  always_comb
  begin
    case (hsize_i)
      3'b000 : ap_be = 4'b0001 << haddr_i[1:0];
      3'b001 : ap_be = haddr_i[1] ? 4'b1100 : 4'b0011;
      default: ap_be = 4'b1111;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      dp_act_q   <= 1'b0;
      dp_write_q <= 1'b0;
      dp_err_q   <= 1'b0;
      dp_wait_q  <= 1'b0;
      stall_q    <= 1'b0;
    end
    else if (hready_o)
    begin
      dp_act_q   <= ap_valid;
      dp_write_q <= hwrite_i;
      dp_err_q   <= ap_valid & ap_err;
      dp_wait_q  <= ap_valid & haddr_i[4];
      stall_q    <= 1'b0;
    end
    else
      stall_q <= 1'b1;
  end

  always_ff @(posedge HCLK)
  begin
    if (hready_o)
    begin
      dp_idx_q <= haddr_i[AW+1:2];
      dp_be_q  <= ap_be;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data phase
  ////////////////////////////////////////////////////////////////////////////
  // error and wait both take exactly one low cycle
  assign hready_o = ~dp_act_q | ~(dp_err_q | dp_wait_q) | stall_q;
  assign hresp_o  = (dp_act_q & dp_err_q) ? HRESP_ERROR : HRESP_OKAY;
  assign hrdata_o = mem[dp_idx_q];           // full word, master picks lanes

  always_ff @(posedge HCLK)
  begin
    if (hready_o && dp_act_q && dp_write_q && !dp_err_q)
    begin
      for (int i = 0; i < 4; i++)
        if (dp_be_q[i])
          mem[dp_idx_q][8*i +: 8] <= hwdata_i[8*i +: 8];
    end
  end

  // ERROR with HREADY high only as the second half of the pair
  a_err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (hresp_o == HRESP_ERROR && hready_o) |->
      $past(hresp_o == HRESP_ERROR && !hready_o))
    else $error("sram: ERROR response not two cycles");

endmodule

// ==== logic/biu_ahb_fsm.sv ====
////////////////////////////////////////////////////////////////////////////
// single AHB3-Lite master, no BUSY and no lock
// ERROR aborts the running burst, remaining beats are dropped
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "biu_consts.svh"

module biu_ahb_fsm
  import biu_pkg::*;
(
  input  logic                HCLK,
  input  logic                HRESETn,
  input  logic                biu_stb_i,
  input  biu_size_t           biu_size_i,
  input  biu_type_t           biu_type_i,
  input  biu_prot_t           biu_prot_i,
  input  logic                biu_we_i,
  input  logic                hready_i,
  input  hresp_t              hresp_i,
  input  logic                last_i,     // beat counter at zero
  output logic                hsel_o,
  output htrans_t             htrans_o,
  output logic                hwrite_o,
  output logic [2:0]          hsize_o,
  output hburst_t             hburst_o,
  output logic [`HPROT_W-1:0] hprot_o,
  output logic                cnt_load_o,
  output logic                cnt_step_o,
  output logic                cnt_clear_o,
  output logic                biu_stb_ack_o,
  output logic                biu_d_ack_o,
  output logic                biu_ack_o,
  output logic                biu_err_o
);

  typedef enum logic [1:0] {IDLE, BURST, INCR_RUN} state_t;

  state_t state_q;
  logic   dphase_q;    // data phase of a real transfer in progress
  logic   err_first;   // first cycle of two-cycle ERROR
  logic   incr_cont;   // strobe continues the open INCR burst

  function automatic logic [2:0] size2hsize(input biu_size_t s);
    case (s)
      BYTE   : return 3'b000;
      HWORD  : return 3'b001;
      default: return 3'b010;
    endcase
  endfunction

  function automatic logic [`HPROT_W-1:0] prot2hprot(input biu_prot_t p);
    logic [`HPROT_W-1:0] h;
    h = '0;
    if (p.data)  h = h | `HPROT_DATA;
    if (p.priv)  h = h | `HPROT_PRIV;
    if (p.cache) h = h | `HPROT_CACHE;
    return h;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // handshake and counter control
  ////////////////////////////////////////////////////////////////////////////
  assign err_first = ~hready_i & (hresp_i == HRESP_ERROR);
  assign incr_cont = (state_q == INCR_RUN) & (biu_type_i == INCR);

  assign biu_stb_ack_o = hready_i & last_i & biu_stb_i & ~biu_err_o;
  assign biu_d_ack_o   = hready_i & htrans_o[1];   // NONSEQ or SEQ on bus
  assign biu_ack_o     = hready_i & dphase_q;

  assign cnt_load_o  = biu_stb_ack_o & ~incr_cont;   // new NONSEQ
  assign cnt_step_o  = hready_i & (((state_q == BURST) & ~last_i) |
                                   (biu_stb_ack_o & incr_cont));
  assign cnt_clear_o = err_first;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q   <= IDLE;
      dphase_q  <= 1'b0;
      biu_err_o <= 1'b0;
      hsel_o    <= 1'b0;
      htrans_o  <= HTRANS_IDLE;
      hwrite_o  <= 1'b0;
      hsize_o   <= 3'b000;
      hburst_o  <= HBURST_SINGLE;
      hprot_o   <= '0;
    end
    else
    begin
      biu_err_o <= 1'b0;                      // one-cycle pulse
      if (err_first)
      begin
        state_q   <= IDLE;                    // abandon the burst
        dphase_q  <= 1'b0;                    // no ack for failed beat
        hsel_o    <= 1'b0;
        htrans_o  <= HTRANS_IDLE;             // IDLE in second ERROR cycle
        biu_err_o <= 1'b1;
      end
      else if (hready_i)
      begin
        dphase_q <= htrans_o[1];
        if (cnt_load_o)
        begin
          state_q  <= (biu_type_i == INCR) ? INCR_RUN : BURST;
          hsel_o   <= 1'b1;
          htrans_o <= HTRANS_NONSEQ;
          hwrite_o <= biu_we_i;
          hsize_o  <= size2hsize(biu_size_i);
          hburst_o <= biu_type2hburst(biu_type_i);
          hprot_o  <= prot2hprot(biu_prot_i);
        end
        else if (cnt_step_o)
          htrans_o <= HTRANS_SEQ;             // state unchanged
        else
        begin
          state_q  <= IDLE;
          hsel_o   <= 1'b0;
          htrans_o <= HTRANS_IDLE;
        end
      end
    end
  end

  // a burst always opens with NONSEQ
  a_no_seq_after_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (htrans_o == HTRANS_IDLE) |=> (htrans_o != HTRANS_SEQ))
    else $error("fsm: SEQ directly after IDLE");

  // slave never issues back-to-back ERROR starts
  a_err_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
    biu_err_o |=> !biu_err_o)
    else $error("fsm: biu_err_o high two cycles");

endmodule

// ==== logic/biu_ahb_top.sv ====
////////////////////////////////////////////////////////////////////////////
// BIU master with local SRAM slave, core holds requests until stb_ack
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "biu_consts.svh"

module biu_ahb_top
  import biu_pkg::*;
(
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   biu_stb_i,
  input  logic [`BIU_ADDR_W-1:0] biu_adri_i,
  input  biu_size_t              biu_size_i,
  input  biu_type_t              biu_type_i,
  input  biu_prot_t              biu_prot_i,
  input  logic                   biu_we_i,
  input  logic [`BIU_DATA_W-1:0] biu_d_i,
  input  logic [`BIU_TAG_W-1:0]  biu_tagi_i,
  output logic                   biu_stb_ack_o,  // request taken
  output logic                   biu_d_ack_o,    // next write word wanted
  output logic [`BIU_ADDR_W-1:0] biu_adro_o,
  output logic [`BIU_DATA_W-1:0] biu_q_o,
  output logic                   biu_ack_o,      // beat done
  output logic                   biu_err_o,
  output logic [`BIU_TAG_W-1:0]  biu_tago_o
);

  // internal AHB bus
  logic                   hsel, hwrite, hready;
  htrans_t                htrans;
  hresp_t                 hresp;
  logic [2:0]             hsize;
  logic [`HPROT_W-1:0]    hprot;
  logic [`BIU_ADDR_W-1:0] haddr;
  logic [`BIU_DATA_W-1:0] hwdata, hrdata;

  logic                   cnt_load, cnt_step, cnt_clear, cnt_last;
  logic [`BIU_TAG_W-1:0]  tag_a;        // tag of the address phase
  logic [`BIU_DATA_W-1:0] wdata_d;      // core data one accepted cycle late
  biu_meta_t              meta_a, meta_d;

  biu_ahb_fsm u_fsm (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .biu_stb_i (biu_stb_i), .biu_size_i (biu_size_i),
    .biu_type_i (biu_type_i), .biu_prot_i (biu_prot_i), .biu_we_i (biu_we_i),
    .hready_i (hready), .hresp_i (hresp), .last_i (cnt_last),
    .hsel_o (hsel), .htrans_o (htrans), .hwrite_o (hwrite), .hsize_o (hsize),
    .hburst_o (),                       // SRAM slave ignores HBURST
    .hprot_o (hprot),
    .cnt_load_o (cnt_load), .cnt_step_o (cnt_step), .cnt_clear_o (cnt_clear),
    .biu_stb_ack_o (biu_stb_ack_o), .biu_d_ack_o (biu_d_ack_o),
    .biu_ack_o (biu_ack_o), .biu_err_o (biu_err_o)
  );

  biu_burst_cnt u_cnt (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .load_i (cnt_load), .step_i (cnt_step), .clear_i (cnt_clear),
    .addr_i (biu_adri_i), .type_i (biu_type_i), .size_i (biu_size_i),
    .tag_i (biu_tagi_i),
    .haddr_o (haddr), .tag_o (tag_a), .last_o (cnt_last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // data phase alignment
  ////////////////////////////////////////////////////////////////////////////
  biu_data_pipe #(.payload_t (logic [`BIU_DATA_W-1:0])) wdata_dly (
    .HCLK (HCLK), .en_i (hready), .d_i (biu_d_i), .q_o (wdata_d)
  );

  biu_data_pipe #(.payload_t (logic [`BIU_DATA_W-1:0])) wdata_out (
    .HCLK (HCLK), .en_i (hready), .d_i (wdata_d), .q_o (hwdata)
  );

  assign meta_a.addr = haddr;
  assign meta_a.tag  = tag_a;

  biu_data_pipe #(.payload_t (biu_meta_t)) meta_pipe (
    .HCLK (HCLK), .en_i (hready), .d_i (meta_a), .q_o (meta_d)
  );

  assign biu_adro_o = meta_d.addr;
  assign biu_tago_o = meta_d.tag;
  assign biu_q_o    = hrdata;          // valid while biu_ack_o

  ahb_sram_slave u_sram (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .hsel_i (hsel), .htrans_i (htrans), .haddr_i (haddr), .hwrite_i (hwrite),
    .hsize_i (hsize), .hprot_i (hprot), .hwdata_i (hwdata),
    .hrdata_o (hrdata), .hready_o (hready), .hresp_o (hresp)
  );

endmodule

// ==== logic/biu_burst_cnt.sv ====
////////////////////////////////////////////////////////////////////////////
// address and beat counter, load/step/clear come in HREADY-qualified
// INCR bursts keep the count at zero and take a fresh tag per beat
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "biu_consts.svh"

module biu_burst_cnt
  import biu_pkg::*;
(
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   load_i,
  input  logic                   step_i,
  input  logic                   clear_i,
  input  logic [`BIU_ADDR_W-1:0] addr_i,
  input  biu_type_t              type_i,
  input  biu_size_t              size_i,
  input  logic [`BIU_TAG_W-1:0]  tag_i,
  output logic [`BIU_ADDR_W-1:0] haddr_o,
  output logic [`BIU_TAG_W-1:0]  tag_o,    // tag of current address phase
  output logic                   last_o
);

  logic [3:0] cnt_q;       // beats remaining minus one
  hburst_t    burst_q;
  biu_size_t  size_q;

  // burst length minus one
  function automatic logic [3:0] burst2cnt(input hburst_t b);
    case (b)
      HBURST_WRAP4, HBURST_INCR4  : return 4'd3;
      HBURST_WRAP8, HBURST_INCR8  : return 4'd7;
      HBURST_WRAP16, HBURST_INCR16: return 4'd15;
      default                     : return 4'd0;
    endcase
  endfunction

  // increment, align to size, then keep upper bits for wrapping bursts
  function automatic logic [`BIU_ADDR_W-1:0] nxt_addr(
    input logic [`BIU_ADDR_W-1:0] a,
    input hburst_t                b,
    input biu_size_t              s
  );
    logic [4:0]             sh;
    logic [`BIU_ADDR_W-1:0] lin;
    logic [`BIU_ADDR_W-1:0] keep;
    sh   = {3'b000, s};
    lin  = a + (`BIU_ADDR_W'(1) << sh);
    lin  = lin & ({`BIU_ADDR_W{1'b1}} << sh);
    case (b)
      HBURST_WRAP4 : keep = {`BIU_ADDR_W{1'b1}} << (sh + 5'd2);
      HBURST_WRAP8 : keep = {`BIU_ADDR_W{1'b1}} << (sh + 5'd3);
      HBURST_WRAP16: keep = {`BIU_ADDR_W{1'b1}} << (sh + 5'd4);
      default      : keep = '0;           // linear
    endcase
    return (a & keep) | (lin & ~keep);
  endfunction

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      cnt_q   <= 4'd0;
      burst_q <= HBURST_SINGLE;
      haddr_o <= '0;
    end
    else if (clear_i)
      cnt_q <= 4'd0;                      // burst cut short by ERROR
    else if (load_i)
    begin
      cnt_q   <= burst2cnt(biu_type2hburst(type_i));
      burst_q <= biu_type2hburst(type_i);
      haddr_o <= addr_i;
    end
    else if (step_i)
    begin
      haddr_o <= nxt_addr(haddr_o, burst_q, size_q);
      if (cnt_q != 4'd0)
        cnt_q <= cnt_q - 4'd1;
    end
  end

  // size and tag are payload only
  always_ff @(posedge HCLK)
  begin
    if (load_i && !clear_i)
    begin
      size_q <= size_i;
      tag_o  <= tag_i;
    end
    else if (step_i && !clear_i && burst_q == HBURST_INCR)
      tag_o  <= tag_i;                    // each INCR beat brings its own tag
  end

  assign last_o = (cnt_q == 4'd0);

  // sequencer must not step a fixed burst past its last beat
  a_step_in_range: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (step_i && !clear_i) |-> (cnt_q != 4'd0 || burst_q == HBURST_INCR))
    else $error("burst_cnt: step beyond end of fixed burst");

endmodule

// ==== logic/biu_consts.svh ====
////////////////////////////////////////////////////////////////////////////
// 32-bit data and address only, DWORD transfers are not supported
// SRAM slave decodes a 16 KiB window, its top 1 KiB answers ERROR
////////////////////////////////////////////////////////////////////////////
`ifndef BIU_CONSTS_SVH
`define BIU_CONSTS_SVH

// bus widths
`define BIU_DATA_W 32
`define BIU_ADDR_W 32
`define BIU_TAG_W  8

// HPROT bits, bufferable bit 2 always left clear
`define HPROT_W     4
`define HPROT_DATA  4'b0001  // data access, else opcode fetch
`define HPROT_PRIV  4'b0010  // privileged, else user
`define HPROT_CACHE 4'b1000  // cacheable

// on-chip SRAM slave
`define SRAM_WORDS    4096   // 16 KiB of 32-bit words
`define SRAM_ERR_BASE 'h3C00 // error region up to end of window

`endif

// ==== logic/biu_data_pipe.sv ====
////////////////////////////////////////////////////////////////////////////
// one HREADY-gated stage, no reset, q_o is valid one accepted cycle later
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module biu_data_pipe #(
  parameter type payload_t = logic [31:0]
)
(
  input  logic     HCLK,
  input  logic     en_i,   // HREADY
  input  payload_t d_i,
  output payload_t q_o
);

  // holds while the bus is stalled
  always_ff @(posedge HCLK)
  begin
    if (en_i)
      q_o <= d_i;
  end

endmodule

// ==== logic/biu_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// biu_type_t follows the AHB HBURST encoding order
////////////////////////////////////////////////////////////////////////////
`include "biu_consts.svh"

package biu_pkg;

  // core side transfer size
  typedef enum logic [1:0] {
    BYTE  = 2'd0,
    HWORD = 2'd1,
    WORD  = 2'd2
  } biu_size_t;

  // core side burst type
  typedef enum logic [2:0] {
    SINGLE, INCR, WRAP4, INCR4, WRAP8, INCR8, WRAP16, INCR16
  } biu_type_t;

  // protection flags, data in bit 0
  typedef struct packed {
    logic cache;
    logic priv;
    logic data;
  } biu_prot_t;

  typedef enum logic [1:0] {
    HTRANS_IDLE, HTRANS_BUSY, HTRANS_NONSEQ, HTRANS_SEQ
  } htrans_t;

  typedef enum logic [2:0] {
    HBURST_SINGLE, HBURST_INCR, HBURST_WRAP4, HBURST_INCR4,
    HBURST_WRAP8, HBURST_INCR8, HBURST_WRAP16, HBURST_INCR16
  } hburst_t;

  typedef enum logic {HRESP_OKAY, HRESP_ERROR} hresp_t;

  // address and tag of one beat, follows it into the data phase
  typedef struct packed {
    logic [`BIU_ADDR_W-1:0] addr;
    logic [`BIU_TAG_W-1:0]  tag;
  } biu_meta_t;

  // burst type to HBURST, shared by sequencer and counter
  function automatic hburst_t biu_type2hburst(input biu_type_t t);
    case (t)
      SINGLE : return HBURST_SINGLE;
      INCR   : return HBURST_INCR;
      WRAP4  : return HBURST_WRAP4;
      INCR4  : return HBURST_INCR4;
      WRAP8  : return HBURST_WRAP8;
      INCR8  : return HBURST_INCR8;
      WRAP16 : return HBURST_WRAP16;
      default: return HBURST_INCR16;
    endcase
  endfunction

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the BIU testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_biu_ahb -f files.f \
  -o sim_biu_ahb

./obj_dir/sim_biu_ahb | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run.sh: testbench reported failure"
  exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
  echo "run.sh: no pass line in log"
  exit 1
fi

echo "run.sh: done"

// ==== tests/tb_biu_ahb.sv ====
////////////////////////////////////////////////////////////////////////////
// drives the BIU core port only and checks memory through read-back
// reads touch only locations written earlier in the run
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "biu_consts.svh"

module tb_biu_ahb
  import biu_pkg::*;
;

  typedef struct packed {
    logic [`BIU_ADDR_W-1:0] addr;
    logic [`BIU_TAG_W-1:0]  tag;
    logic [`BIU_DATA_W-1:0] data;
    logic                   rd;
    logic                   err;
  } beat_t;

  logic                   HCLK;
  logic                   HRESETn;
  logic                   biu_stb_i;
  logic [`BIU_ADDR_W-1:0] biu_adri_i;
  biu_size_t              biu_size_i;
  biu_type_t              biu_type_i;
  biu_prot_t              biu_prot_i;
  logic                   biu_we_i;
  logic [`BIU_DATA_W-1:0] biu_d_i;
  logic [`BIU_TAG_W-1:0]  biu_tagi_i;
  logic                   biu_stb_ack_o, biu_d_ack_o, biu_ack_o, biu_err_o;
  logic [`BIU_ADDR_W-1:0] biu_adro_o;
  logic [`BIU_DATA_W-1:0] biu_q_o;
  logic [`BIU_TAG_W-1:0]  biu_tago_o;

  logic [`BIU_DATA_W-1:0] ref_mem [`SRAM_WORDS];  // reference SRAM image
  beat_t                  exp_q [$];                // beats still to complete
  integer                 seed = 90;
  int                     errors = 0;
  int                     timeouts = 0;

  biu_ahb_top DUT (.*);

  initial HCLK = 1'b0;
  always #50 HCLK = ~HCLK;    // 100 ns period

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic int beat_count(input biu_type_t ty);
    case (ty)
      WRAP4, INCR4  : return 4;
      WRAP8, INCR8  : return 8;
      WRAP16, INCR16: return 16;
      default       : return 1;
    endcase
  endfunction

  // step by size, align, keep the wrap boundary bits
  function automatic logic [31:0] next_addr(input logic [31:0] a, input biu_type_t ty,
                                            input biu_size_t sz);
    logic [31:0] step;
    logic [31:0] span;
    logic [31:0] lin;
    step = 32'd1 << sz;
    lin  = (a + step) & ~(step - 32'd1);
    case (ty)
      WRAP4  : span = step * 4;
      WRAP8  : span = step * 8;
      WRAP16 : span = step * 16;
      default: span = 32'd0;
    endcase
    if (span == 32'd0)
      return lin;
    return (a & ~(span - 32'd1)) | (lin & (span - 32'd1));
  endfunction

  function automatic logic model_err(input logic [31:0] a, input logic we, input logic priv);
    return (a[13:0] >= `SRAM_ERR_BASE) || (we && !priv);
  endfunction

  // byte lanes picked from the low address bits
  function automatic void model_write(input logic [31:0] a, input biu_size_t sz,
                                      input logic [31:0] d);
    int lo;
    int n;
    n  = 1 << sz;
    lo = (sz == WORD) ? 0 : (sz == HWORD) ? 2 * a[1] : a[1:0];
    for (int i = 0; i < 4; i++)
      if (i >= lo && i < lo + n)
        ref_mem[a[13:2]][8*i +: 8] = d[8*i +: 8];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////////////////////
  task automatic compare_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // outputs are settled at the falling edge
  always @(negedge HCLK)
  begin
    beat_t e;
    if (HRESETn && (biu_ack_o || biu_err_o))
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("unexpected ack or error with no transfer pending at %0t", $time);
      end
      else
      begin
        e = exp_q.pop_front();
        compare_val("biu_err_o", {31'b0, biu_err_o}, {31'b0, e.err});
        compare_val("biu_ack_o", {31'b0, biu_ack_o}, {31'b0, !e.err});
        if (biu_ack_o)
        begin
          compare_val("biu_adro_o", biu_adro_o, e.addr);
          compare_val("biu_tago_o", {24'b0, biu_tago_o}, {24'b0, e.tag});
          if (e.rd)
            compare_val("biu_q_o", biu_q_o, e.data);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  task automatic set_request(input logic [31:0] addr, input biu_size_t sz,
                             input biu_type_t ty, input logic we, input logic priv,
                             input logic [7:0] tag, input logic [31:0] d);
    biu_stb_i  = 1'b1;
    biu_adri_i = addr;
    biu_size_i = sz;
    biu_type_i = ty;
    biu_we_i   = we;
    biu_prot_i = '{cache: 1'b0, priv: priv, data: 1'b1};
    biu_tagi_i = tag;
    biu_d_i    = d;
  endtask

  // hold the strobe until stb_ack is seen just after the falling edge
  task automatic wait_stb_ack(input string what);
    int t;
    t = 0;
    #1;
    while (!biu_stb_ack_o && t < 100)
    begin
      @(negedge HCLK);
      #1;
      t++;
    end
    if (!biu_stb_ack_o)
    begin
      timeouts++;
      $display("timeout: %s strobe never acknowledged", what);
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < 300)
    begin
      @(negedge HCLK);
      t++;
    end
    if (exp_q.size() != 0)
    begin
      timeouts++;
      $display("timeout: %0d beats never completed", exp_q.size());
      exp_q.delete();
    end
    repeat (2) @(negedge HCLK);
  endtask

  // SINGLE or fixed-length burst from one strobe
  task automatic run_burst(input logic [31:0] addr, input biu_size_t sz,
                           input biu_type_t ty, input logic we, input logic priv);
    logic [31:0] wd [16];
    logic [31:0] a;
    logic [7:0]  tag;
    beat_t       e;
    int          n;
    int          k;
    int          t;
    n   = beat_count(ty);
    tag = 8'($random(seed));
    a   = addr;
    for (int i = 0; i < n; i++)
      wd[i] = $random(seed);
    for (int i = 0; i < n; i++)
    begin
      e.addr = a;
      e.tag  = tag;
      e.rd   = !we;
      e.err  = model_err(a, we, priv);
      e.data = ref_mem[a[13:2]];
      exp_q.push_back(e);
      if (e.err)
        break;          // rest of burst abandoned
      if (we)
        model_write(a, sz, wd[i]);
      a = next_addr(a, ty, sz);
    end
    @(negedge HCLK);
    set_request(addr, sz, ty, we, priv, tag, wd[0]);
    wait_stb_ack("burst");
    @(negedge HCLK);
    biu_stb_i = 1'b0;
    k = 1;
    t = 0;
    while (we && k < n && t < 200)   // next word after each d_ack
    begin
      biu_d_i = wd[k];
      #1;
      if (biu_d_ack_o)
        k++;
      @(negedge HCLK);
      t++;
    end
    if (we && k < n)
    begin
      timeouts++;
      $display("timeout: write data for beat %0d never taken", k);
    end
    wait_drain();
  endtask

  // undefined-length INCR of words ended by dropping the strobe
  task automatic run_incr(input logic [31:0] addr, input logic we, input int len);
    logic [31:0] wd [16];
    logic [31:0] a;
    logic [7:0]  tag0;
    beat_t       e;
    tag0 = 8'($random(seed));
    a    = addr;
    for (int i = 0; i < len; i++)
    begin
      wd[i]  = $random(seed);
      e.addr = a;
      e.tag  = tag0 + 8'(i);     // fresh tag per beat
      e.rd   = !we;
      e.err  = 1'b0;
      e.data = ref_mem[a[13:2]];
      exp_q.push_back(e);
      if (we)
        model_write(a, WORD, wd[i]);
      a = next_addr(a, INCR, WORD);
    end
    @(negedge HCLK);
    for (int i = 0; i < len; i++)
    begin
      set_request(addr, WORD, INCR, we, 1'b1, tag0 + 8'(i), wd[i]);
      wait_stb_ack("INCR");
      @(negedge HCLK);
    end
    biu_stb_i = 1'b0;
    wait_drain();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////
  task automatic finish_run();
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  endtask

  initial
  begin
    logic [31:0] a1;
    logic [31:0] a2;
    int          len;
    HRESETn    = 1'b0;
    biu_stb_i  = 1'b0;
    biu_adri_i = '0;
    biu_size_i = WORD;
    biu_type_i = SINGLE;
    biu_prot_i = '0;
    biu_we_i   = 1'b0;
    biu_d_i    = '0;
    biu_tagi_i = '0;
    repeat (10) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;

    // single write and read-back
    a1 = $random(seed) & 32'h1FFC;
    run_burst(a1, WORD, SINGLE, 1'b1, 1'b1);
    run_burst(a1, WORD, SINGLE, 1'b0, 1'b1);

    // sub-word lanes merged into one word, kept below the error region
    a2 = ($random(seed) & 32'h1BFC) | 32'h2000;
    run_burst(a2, WORD, SINGLE, 1'b1, 1'b1);
    run_burst(a2 | (32'($random(seed)) & 32'h3), BYTE, SINGLE, 1'b1, 1'b1);
    run_burst(a2 | (32'($random(seed)) & 32'h2), HWORD, SINGLE, 1'b1, 1'b1);
    run_burst(a2, WORD, SINGLE, 1'b0, 1'b1);

    // fixed bursts across bit 4 with wait states on the upper halves
    run_burst(32'h100, WORD, INCR8, 1'b1, 1'b1);
    run_burst(32'h100, WORD, INCR8, 1'b0, 1'b1);
    run_burst(32'h118, WORD, WRAP4, 1'b1, 1'b1);
    run_burst(32'h118, WORD, WRAP4, 1'b0, 1'b1);
    run_burst(32'h30C, WORD, INCR4, 1'b1, 1'b1);
    run_burst(32'h30C, WORD, INCR4, 1'b0, 1'b1);
    run_burst(32'h428, WORD, WRAP16, 1'b1, 1'b1);
    run_burst(32'h414, WORD, WRAP16, 1'b0, 1'b1);

    // INCR of random length
    len = 1 + ({$random(seed)} % 6);
    run_incr(32'h508, 1'b1, len);
    run_incr(32'h508, 1'b0, len);

    // error region read and a user write that leaves memory alone
    run_burst(32'h3C10, WORD, SINGLE, 1'b0, 1'b1);
    run_burst(a1, WORD, SINGLE, 1'b1, 1'b0);
    run_burst(a1, WORD, SINGLE, 1'b0, 1'b1);

    // INCR8 running into the error region and normal traffic after it
    run_burst(32'h3BF0, WORD, INCR4, 1'b1, 1'b1);
    run_burst(32'h3BF0, WORD, INCR8, 1'b0, 1'b1);
    run_burst(a1, WORD, SINGLE, 1'b0, 1'b1);

    finish_run();
  end

endmodule
